// ==== design/kiwi_pkg.sv ====
// Kiwi board shared definitions

package kiwi_pkg;

    // Shared RAM between main and sub CPU, 8 KB
    localparam int SHR_AW = 13;

    // CPU side video bus
    localparam int CPU_AW = 13;

    // Tile VRAM, 4 KB
    localparam int VRAM_AW = 12;

    // Palette as bytes, two per colour entry
    localparam int PAL_AW = 9;

    // Fractional clock enable, 24 MHz times 1/4 gives 6 MHz
    localparam logic [3:0] CEN_N = 4'd1;
    localparam logic [3:0] CEN_M = 4'd4;

    // Accumulator width for the enable generator
    localparam int CEN_WC = 4;

    // Main CPU ROM, byte addressed
    localparam int MAIN_AW = 17;

    // Scroll graphics ROM, 32-bit words
    localparam int SCR_AW = 18;

    // One main ROM byte
    typedef logic [7:0] main_rom_t;

    // One scroll graphics word, eight 4-bit pixels
    typedef logic [31:0] scr_rom_t;

endpackage

// ==== design/kiwi_frac_cen.sv ====
// Kiwi fractional clock enables
`timescale 1ns/1ps

module kiwi_frac_cen (
    input        clk24,
    input        rst,
    output logic cen6,
    output logic cen3,
    output logic cen1p5
);
    import kiwi_pkg::*;

    // Fractional accumulator state
    logic [CEN_WC-1:0] acc;
    logic [CEN_WC-1:0] sum;
    logic              tick;

    // Counts cen6 pulses for the slower enables
    logic [1:0]        div_cnt;

    // Next accumulator value before wrap
    assign sum  = acc + CEN_N;
    assign tick = (sum >= CEN_M);

    always_ff @(posedge clk24) begin
        if (rst) begin
            acc     <= '0;
            div_cnt <= 2'd0;
            cen6    <= 1'b0;
            cen3    <= 1'b0;
            cen1p5  <= 1'b0;
        end else begin
            cen6   <= tick;
            // Half rate aligned to the first cen6 pulse
            cen3   <= tick && !div_cnt[0];
            // Quarter rate with the same alignment
            cen1p5 <= tick && (div_cnt == 2'd0);
            if (tick) begin
                // Wrap and keep the remainder
                acc     <= sum - CEN_M;
                div_cnt <= div_cnt + 2'd1;
            end else begin
                acc <= sum;
            end
        end
    end

    // 3 MHz enable repeats every eight cycles once running
    a_cen3_period : assert property (
        @(posedge clk24) disable iff (rst) cen3 |=> !cen3 [*7] ##1 cen3
    ) else $error("cen3 period is not eight cycles");

endmodule

// ==== design/kiwi_shared_ram.sv ====
// Kiwi main/sub shared RAM
`timescale 1ns/1ps

module kiwi_shared_ram (
    input                             clk24,
    // Main CPU port
    input        [kiwi_pkg::SHR_AW-1:0] main_addr,
    input        [7:0]                main_din,
    input                             main_we,
    output logic [7:0]                main_dout,
    // Sub CPU port
    input        [kiwi_pkg::SHR_AW-1:0] sub_addr,
    input        [7:0]                sub_din,
    input                             sub_we,
    output logic [7:0]                sub_dout
);
    import kiwi_pkg::*;

    // 8 KB byte array
    logic [7:0] mem [0:2**SHR_AW-1];

    // Sub write loses when both ports hit one address
    logic       sub_blocked;

    assign sub_blocked = main_we && (main_addr == sub_addr);

    // Write side of both ports
    always_ff @(posedge clk24) begin
        if (main_we) begin
            mem[main_addr] <= main_din;
        end
        if (sub_we && !sub_blocked) begin
            mem[sub_addr] <= sub_din;
        end
    end

    // Main read, old data on a same-edge write
    always_ff @(posedge clk24) begin
        main_dout <= mem[main_addr];
    end

    // Sub read, same timing
    always_ff @(posedge clk24) begin
        sub_dout <= mem[sub_addr];
    end

    // Write addresses must be resolved
    a_main_addr_known : assert property (
        @(posedge clk24) main_we |-> !$isunknown(main_addr)
    ) else $error("main write with unknown address");

    a_sub_addr_known : assert property (
        @(posedge clk24) sub_we |-> !$isunknown(sub_addr)
    ) else $error("sub write with unknown address");

endmodule

// ==== design/kiwi_vmem.sv ====
// Kiwi video memory and scan pipeline
`timescale 1ns/1ps

module kiwi_vmem (
    input                               clk24,
    input                               rst,
    // CPU bus
    input        [kiwi_pkg::CPU_AW-1:0]  cpu_addr,
    input        [7:0]                  cpu_dout,
    input                               cpu_rnw,
    input                               vram_cs,
    input                               pal_cs,
    input                               vctrl_cs,
    output logic [7:0]                  vram_dout,
    output logic [7:0]                  pal_dout,
    output logic                        flip,
    // Scan side
    input        [kiwi_pkg::VRAM_AW-1:0] scan_addr,
    output logic [4:0]                  red,
    output logic [4:0]                  green,
    output logic [4:0]                  blue
);
    import kiwi_pkg::*;

    // Tile memory
    logic [7:0] vram   [0:2**VRAM_AW-1];
    // Palette split by byte lane, low and high byte of each entry
    logic [7:0] pal_lo [0:2**(PAL_AW-1)-1];
    logic [7:0] pal_hi [0:2**(PAL_AW-1)-1];

    // CPU side decode
    logic [VRAM_AW-1:0] cpu_vaddr;
    logic [PAL_AW-2:0]  cpu_pidx;
    logic               cpu_wr;
    logic [7:0]         pal_lo_q;
    logic [7:0]         pal_hi_q;
    logic               pal_sel;

    // Scan pipeline
    logic [VRAM_AW-1:0] scan_eff;
    logic [7:0]         tile;
    logic [7:0]         scan_lo;
    logic [7:0]         scan_hi;
    logic [14:0]        rgb;

    assign cpu_vaddr = cpu_addr[VRAM_AW-1:0];
    assign cpu_pidx  = cpu_addr[PAL_AW-1:1];
    assign cpu_wr    = !cpu_rnw;

    // VRAM CPU port
    always_ff @(posedge clk24) begin
        if (vram_cs && cpu_wr) begin
            vram[cpu_vaddr] <= cpu_dout;
        end
        vram_dout <= vram[cpu_vaddr];
    end

    // Palette CPU port, bit 0 picks the lane
    always_ff @(posedge clk24) begin
        if (pal_cs && cpu_wr) begin
            if (cpu_addr[0]) begin
                pal_hi[cpu_pidx] <= cpu_dout;
            end else begin
                pal_lo[cpu_pidx] <= cpu_dout;
            end
        end
        pal_lo_q <= pal_lo[cpu_pidx];
        pal_hi_q <= pal_hi[cpu_pidx];
        pal_sel  <= cpu_addr[0];
    end

    assign pal_dout = pal_sel ? pal_hi_q : pal_lo_q;

    // Video control, only flip is kept
    always_ff @(posedge clk24) begin
        if (rst) begin
            flip <= 1'b0;
        end else if (vctrl_cs && cpu_wr) begin
            flip <= cpu_dout[0];
        end
    end

    // Flipped screen scans VRAM backwards
    assign scan_eff = flip ? ~scan_addr : scan_addr;

    // Stage 1, tile byte
    always_ff @(posedge clk24) begin
        tile <= vram[scan_eff];
    end

    // Stage 2, both colour bytes at once
    always_ff @(posedge clk24) begin
        scan_lo <= pal_lo[tile];
        scan_hi <= pal_hi[tile];
    end

    // RGB555 from the high/low pair, top bit unused
    assign rgb   = {scan_hi[6:0], scan_lo};
    assign red   = rgb[14:10];
    assign green = rgb[9:5];
    assign blue  = rgb[4:0];

    // Address decoder upstream gives exclusive selects
    a_cs_exclusive : assert property (
        @(posedge clk24) disable iff (rst) $onehot0({vram_cs, pal_cs, vctrl_cs})
    ) else $error("more than one video chip select active");

endmodule

// ==== design/kiwi_rom_slot.sv ====
// Kiwi ROM slot with SDRAM request
`timescale 1ns/1ps

module kiwi_rom_slot #(
    parameter type data_t = logic [7:0],
    parameter int  AW     = 17
) (
    input                 clk24,
    input                 rst,
    // Client side with cs/ok
    input                 cs,
    input        [AW-1:0] addr,
    output logic          ok,
    output data_t         data,
    // SDRAM side with four-phase req/ack
    output logic          req,
    output logic [AW-1:0] req_addr,
    input                 ack,
    input  data_t         req_data
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait_ack,
        st_wait_rel
    } state_t;

    state_t        state;

    // One-entry cache
    logic [AW-1:0] cache_addr;
    logic          cache_valid;
    data_t         cache_data;

    logic          hit;
    logic          start;
    logic          fill;

    assign hit   = cache_valid && (cache_addr == addr);
    // New request only once the previous ack is gone
    assign start = (state == st_idle) && cs && !hit && !ack;
    assign fill  = (state == st_wait_ack) && ack;

    // Client always reads the cached word
    assign data = cache_data;

    // Handshake control
    always_ff @(posedge clk24) begin
        if (rst) begin
            state       <= st_idle;
            req         <= 1'b0;
            ok          <= 1'b0;
            cache_valid <= 1'b0;
        end else begin
            // ok follows cs and addr with one cycle of delay
            ok <= (state == st_idle) && cs && hit;
            case (state)
                st_idle: begin
                    if (start) begin
                        req   <= 1'b1;
                        state <= st_wait_ack;
                    end
                end
                st_wait_ack: begin
                    if (ack) begin
                        req         <= 1'b0;
                        cache_valid <= 1'b1;
                        state       <= st_wait_rel;
                    end
                end
                st_wait_rel: begin
                    // Back to idle once the responder releases ack
                    if (!ack) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Request address and cache contents
    always_ff @(posedge clk24) begin
        if (start) begin
            req_addr <= addr;
        end
        if (fill) begin
            cache_addr <= req_addr;
            cache_data <= req_data;
        end
    end

    // Responder holds ack until req is gone
    a_ack_release : assert property (
        @(posedge clk24) disable iff (rst) $fell(ack) |-> !req
    ) else $error("ack dropped while req high");

    // Responder must have released ack before a new request
    a_req_after_ack : assert property (
        @(posedge clk24) disable iff (rst) $rose(req) |-> !ack
    ) else $error("req rose while ack high");

endmodule

// ==== design/kiwi_game.sv ====
// Kiwi board memory and timing core
`timescale 1ns/1ps

module kiwi_game (
    input                                clk24,
    input                                rst,
    output logic                         cen6,
    output logic                         cen3,
    output logic                         cen1p5,
    // Shared RAM, main CPU side
    input        [kiwi_pkg::SHR_AW-1:0]  main_shr_addr,
    input        [7:0]                   main_shr_din,
    input                                main_shr_we,
    output logic [7:0]                   main_shr_dout,
    // Shared RAM, sub CPU side
    input        [kiwi_pkg::SHR_AW-1:0]  sub_shr_addr,
    input        [7:0]                   sub_shr_din,
    input                                sub_shr_we,
    output logic [7:0]                   sub_shr_dout,
    // CPU video bus
    input        [kiwi_pkg::CPU_AW-1:0]  cpu_addr,
    input        [7:0]                   cpu_dout,
    input                                cpu_rnw,
    input                                vram_cs,
    input                                pal_cs,
    input                                vctrl_cs,
    output logic [7:0]                   vram_dout,
    output logic [7:0]                   pal_dout,
    output logic                         flip,
    // Scan and pixels
    input        [kiwi_pkg::VRAM_AW-1:0] scan_addr,
    output logic [4:0]                   red,
    output logic [4:0]                   green,
    output logic [4:0]                   blue,
    // Main ROM client
    input        [kiwi_pkg::MAIN_AW-1:0] main_addr,
    input                                main_cs,
    output logic                         main_ok,
    output kiwi_pkg::main_rom_t          main_data,
    // Scroll ROM client
    input        [kiwi_pkg::SCR_AW-1:0]  scr_addr,
    input                                scr_cs,
    output logic                         scr_ok,
    output kiwi_pkg::scr_rom_t           scr_data,
    // SDRAM, main ROM slot
    output logic                         main_req,
    input                                main_ack,
    output logic [kiwi_pkg::MAIN_AW-1:0] main_req_addr,
    input  kiwi_pkg::main_rom_t          main_req_data,
    // SDRAM, scroll ROM slot
    output logic                         scr_req,
    input                                scr_ack,
    output logic [kiwi_pkg::SCR_AW-1:0]  scr_req_addr,
    input  kiwi_pkg::scr_rom_t           scr_req_data
);
    import kiwi_pkg::*;

    // 6, 3 and 1.5 MHz enables from 24 MHz
    kiwi_frac_cen u_cen (
        .clk24     ( clk24         ),
        .rst       ( rst           ),
        .cen6      ( cen6          ),
        .cen3      ( cen3          ),
        .cen1p5    ( cen1p5        )
    );

    // Main/sub mailbox RAM
    kiwi_shared_ram u_shr (
        .clk24     ( clk24         ),
        .main_addr ( main_shr_addr ),
        .main_din  ( main_shr_din  ),
        .main_we   ( main_shr_we   ),
        .main_dout ( main_shr_dout ),
        .sub_addr  ( sub_shr_addr  ),
        .sub_din   ( sub_shr_din   ),
        .sub_we    ( sub_shr_we    ),
        .sub_dout  ( sub_shr_dout  )
    );

    // VRAM, palette and pixel path
    kiwi_vmem u_vmem (
        .clk24     ( clk24         ),
        .rst       ( rst           ),
        .cpu_addr  ( cpu_addr      ),
        .cpu_dout  ( cpu_dout      ),
        .cpu_rnw   ( cpu_rnw       ),
        .vram_cs   ( vram_cs       ),
        .pal_cs    ( pal_cs        ),
        .vctrl_cs  ( vctrl_cs      ),
        .vram_dout ( vram_dout     ),
        .pal_dout  ( pal_dout      ),
        .flip      ( flip          ),
        .scan_addr ( scan_addr     ),
        .red       ( red           ),
        .green     ( green         ),
        .blue      ( blue          )
    );

    // Main CPU program bytes
    kiwi_rom_slot #(
        .data_t    ( main_rom_t        ),
        .AW        ( $bits(main_addr)  )
    ) u_main_rom (
        .clk24     ( clk24         ),
        .rst       ( rst           ),
        .cs        ( main_cs       ),
        .addr      ( main_addr     ),
        .ok        ( main_ok       ),
        .data      ( main_data     ),
        .req       ( main_req      ),
        .req_addr  ( main_req_addr ),
        .ack       ( main_ack      ),
        .req_data  ( main_req_data )
    );

    // Scroll tile graphics
    kiwi_rom_slot #(
        .data_t    ( scr_rom_t         ),
        .AW        ( $bits(scr_addr)   )
    ) u_scr_rom (
        .clk24     ( clk24         ),
        .rst       ( rst           ),
        .cs        ( scr_cs        ),
        .addr      ( scr_addr      ),
        .ok        ( scr_ok        ),
        .data      ( scr_data      ),
        .req       ( scr_req       ),
        .req_addr  ( scr_req_addr  ),
        .ack       ( scr_ack       ),
        .req_data  ( scr_req_data  )
    );

endmodule

// ==== testbench/tb_sdram_model.sv ====
// SDRAM four-phase responder model
`timescale 1ns/1ps

module tb_sdram_model #(
    parameter type         data_t  = logic [7:0],
    parameter int          AW      = 17,
    parameter logic [31:0] PATTERN = 32'h0,
    parameter logic [31:0] SEED    = 32'h1
) (
    input                 clk24,
    input                 rst,
    input                 req,
    input        [AW-1:0] req_addr,
    output logic          ack,
    output data_t         data
);

    // Delay generator state
    logic [31:0] rng = SEED;
    logic [2:0]  delay;
    logic        busy;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    always @(posedge clk24) begin
        if (rst) begin
            ack   <= 1'b0;
            busy  <= 1'b0;
            delay <= 3'd0;
        end else if (busy) begin
            // Count down, then answer with address-derived data
            if (delay == 3'd0) begin
                ack  <= 1'b1;
                data <= data_t'(32'(req_addr) ^ PATTERN);
                busy <= 1'b0;
            end else begin
                delay <= delay - 3'd1;
            end
        end else if (req && !ack) begin
            // New request, pick 0 to 7 extra cycles
            rng = xorshift(rng);
            delay <= rng[2:0];
            busy  <= 1'b1;
        end else if (ack && !req) begin
            ack <= 1'b0;
        end
    end

endmodule

// ==== testbench/tb_kiwi_game.sv ====
// Kiwi core testbench
`timescale 1ns/1ps

module tb_kiwi_game;
    import kiwi_pkg::*;

    localparam logic [31:0] SEED        = 32'hd69ee02e;
    localparam logic [31:0] ROM_PATTERN = 32'h5a3c96e1;
    // Cycle budget of each test
    localparam int T_CEN  = 70;
    localparam int T_SHR  = 420;
    localparam int T_VID  = 5040;
    localparam int T_SCAN = 320;
    localparam int T_ROM  = 640;
    localparam int CYCLE_LIMIT = 2 * (5 + T_CEN + T_SHR + T_VID + T_SCAN + T_ROM);

    logic clk24;
    logic rst;
    logic cen6, cen3, cen1p5;
    logic [SHR_AW-1:0] main_shr_addr, sub_shr_addr;
    logic [7:0] main_shr_din, sub_shr_din, main_shr_dout, sub_shr_dout;
    logic main_shr_we, sub_shr_we;
    logic [CPU_AW-1:0] cpu_addr;
    logic [7:0] cpu_dout, vram_dout, pal_dout;
    logic cpu_rnw, vram_cs, pal_cs, vctrl_cs, flip;
    logic [VRAM_AW-1:0] scan_addr;
    logic [4:0] red, green, blue;
    logic [MAIN_AW-1:0] main_addr, main_req_addr;
    logic [SCR_AW-1:0] scr_addr, scr_req_addr;
    logic main_cs, main_ok, scr_cs, scr_ok;
    logic main_req, main_ack, scr_req, scr_ack;
    main_rom_t main_data, main_req_data;
    scr_rom_t scr_data, scr_req_data;

    // Reference copies of the memories
    logic [7:0] shr_tb [0:15];
    logic [7:0] vram_tb [0:2**VRAM_AW-1];
    logic [7:0] pal_tb [0:2**PAL_AW-1];
    logic flip_state = 1'b0;
    logic [31:0] rng = SEED;
    int errors = 0;
    int tests = 0;
    int cycles = 0;
    int since_rst = 0;
    logic [2:0] exp_cen;

    // Expected values with stage 0 set by the stimulus
    logic shr_chk_0 = 0, shr_chk_1 = 0, vram_chk_0 = 0, vram_chk_1 = 0;
    logic pal_chk_0 = 0, pal_chk_1 = 0, rgb_chk_0 = 0, rgb_chk_1 = 0, rgb_chk_2 = 0;
    logic [7:0] exp_main_0, exp_main_1, exp_sub_0, exp_sub_1;
    logic [7:0] exp_vram_0, exp_vram_1, exp_pal_0, exp_pal_1;
    logic [14:0] exp_rgb_0, exp_rgb_1, exp_rgb_2;
    logic exp_flip = 1'b0;
    logic main_rep = 1'b0, scr_rep = 1'b0;

    kiwi_game i_dut (.*);

    tb_sdram_model #(.data_t(main_rom_t), .AW(MAIN_AW), .PATTERN(ROM_PATTERN), .SEED(SEED))
        u_main_sdram (.clk24(clk24), .rst(rst), .req(main_req), .req_addr(main_req_addr),
                      .ack(main_ack), .data(main_req_data));
    tb_sdram_model #(.data_t(scr_rom_t), .AW(SCR_AW), .PATTERN(ROM_PATTERN), .SEED(~SEED))
        u_scr_sdram (.clk24(clk24), .rst(rst), .req(scr_req), .req_addr(scr_req_addr),
                     .ack(scr_ack), .data(scr_req_data));

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function void report_fail(input string msg);
        errors++;
        $display("[FAIL] %0d ns: %s", $time, msg);
    endfunction

    // {cen6, cen3, cen1p5} for n cycles after reset
    function automatic logic [2:0] cen_expect(input int n);
        if (n < 4 || n % 4 != 0) begin
            return 3'b000;
        end
        return {1'b1, (n - 4) % 8 == 0, (n - 4) % 16 == 0};
    endfunction

    assign exp_cen = cen_expect(since_rst);

    initial begin
        clk24 = 1'b0;
        forever #5 clk24 = ~clk24;
    end

    // Cycle count, post-reset count and the timeout
    always @(posedge clk24) begin
        cycles <= cycles + 1;
        since_rst <= rst ? 0 : since_rst + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("Run timed out after %0d cycles", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // Line up expectations with DUT latency
    always @(posedge clk24) begin
        shr_chk_1  <= shr_chk_0;
        exp_main_1 <= exp_main_0;
        exp_sub_1  <= exp_sub_0;
        vram_chk_1 <= vram_chk_0;
        exp_vram_1 <= exp_vram_0;
        pal_chk_1  <= pal_chk_0;
        exp_pal_1  <= exp_pal_0;
        rgb_chk_1  <= rgb_chk_0;
        rgb_chk_2  <= rgb_chk_1;
        exp_rgb_1  <= exp_rgb_0;
        exp_rgb_2  <= exp_rgb_1;
    end

    a_cen : assert property (@(posedge clk24) disable iff (rst)
        {cen6, cen3, cen1p5} == exp_cen) else report_fail("clock enable pattern wrong");
    a_cen_slow : assert property (@(posedge clk24) disable iff (rst)
        (cen3 || cen1p5) |-> cen6) else report_fail("slow enable without cen6");
    a_shr : assert property (@(posedge clk24) shr_chk_1 |->
        main_shr_dout == exp_main_1 && sub_shr_dout == exp_sub_1)
        else report_fail("shared RAM read data wrong");
    a_vram : assert property (@(posedge clk24) vram_chk_1 |-> vram_dout == exp_vram_1)
        else report_fail("VRAM read data wrong");
    a_pal : assert property (@(posedge clk24) pal_chk_1 |-> pal_dout == exp_pal_1)
        else report_fail("palette read data wrong");
    a_flip : assert property (@(posedge clk24) disable iff (rst) flip == exp_flip)
        else report_fail("flip register wrong");
    a_rgb : assert property (@(posedge clk24) rgb_chk_2 |-> {red, green, blue} == exp_rgb_2)
        else report_fail("scan RGB555 wrong");
    a_main_data : assert property (@(posedge clk24) disable iff (rst)
        main_ok |-> main_data == main_rom_t'(32'(main_addr) ^ ROM_PATTERN))
        else report_fail("main ROM data wrong");
    a_scr_data : assert property (@(posedge clk24) disable iff (rst)
        scr_ok |-> scr_data == scr_rom_t'(32'(scr_addr) ^ ROM_PATTERN))
        else report_fail("scroll ROM data wrong");
    a_main_hit : assert property (@(posedge clk24) main_rep && $rose(main_cs) |=> main_ok)
        else report_fail("main ROM cached fetch not ready after one cycle");
    a_scr_hit : assert property (@(posedge clk24) scr_rep && $rose(scr_cs) |=> scr_ok)
        else report_fail("scroll ROM cached fetch not ready after one cycle");
    a_main_noreq : assert property (@(posedge clk24) main_rep |-> !main_req)
        else report_fail("main ROM request on cached address");
    a_scr_noreq : assert property (@(posedge clk24) scr_rep |-> !scr_req)
        else report_fail("scroll ROM request on cached address");
    // SDRAM request carries the address the client holds
    a_main_req_addr : assert property (@(posedge clk24) disable iff (rst)
        main_req |-> main_req_addr == main_addr)
        else report_fail("main ROM request address wrong");
    a_scr_req_addr : assert property (@(posedge clk24) disable iff (rst)
        scr_req |-> scr_req_addr == scr_addr)
        else report_fail("scroll ROM request address wrong");
    // Four-phase order where ack follows req and req follows inverted ack
    a_main_ack : assert property (@(posedge clk24) disable iff (rst)
        $changed(main_ack) |-> main_ack == main_req) else report_fail("main ack out of order");
    a_main_req : assert property (@(posedge clk24) disable iff (rst)
        $changed(main_req) |-> main_req != main_ack) else report_fail("main req out of order");
    a_scr_ack : assert property (@(posedge clk24) disable iff (rst)
        $changed(scr_ack) |-> scr_ack == scr_req) else report_fail("scroll ack out of order");
    a_scr_req : assert property (@(posedge clk24) disable iff (rst)
        $changed(scr_req) |-> scr_req != scr_ack) else report_fail("scroll req out of order");

    task finish_test(input string name);
        tests++;
        $display("Test %0d (%s) done, %0d errors so far", tests, name, errors);
    endtask

    task shared_ram_traffic;
        logic [SHR_AW-1:0] ma;
        logic [SHR_AW-1:0] sa;
        logic mw;
        logic sw;
        // Preload the 16-byte window through the main port
        for (int i = 0; i < 16; i++) begin
            rng = xorshift(rng);
            @(posedge clk24);
            main_shr_addr <= {9'h1a3, 4'(i)};
            main_shr_din  <= rng[7:0];
            main_shr_we   <= 1'b1;
            shr_tb[i] = rng[7:0];
        end
        for (int i = 0; i < 400; i++) begin
            rng = xorshift(rng);
            ma = {9'h1a3, rng[3:0]};
            sa = {9'h1a3, rng[7:4]};
            mw = rng[24];
            sw = rng[25];
            // Every fourth cycle a double write to one address
            if (i % 4 == 0) begin
                sa = ma;
                mw = 1'b1;
                sw = 1'b1;
            end
            @(posedge clk24);
            main_shr_addr <= ma;
            main_shr_din  <= rng[15:8];
            main_shr_we   <= mw;
            sub_shr_addr  <= sa;
            sub_shr_din   <= rng[23:16];
            sub_shr_we    <= sw;
            exp_main_0 <= shr_tb[ma[3:0]];
            exp_sub_0  <= shr_tb[sa[3:0]];
            shr_chk_0  <= 1'b1;
            if (sw) shr_tb[sa[3:0]] = rng[23:16];
            if (mw) shr_tb[ma[3:0]] = rng[15:8];
        end
        @(posedge clk24);
        main_shr_we <= 1'b0;
        sub_shr_we  <= 1'b0;
        shr_chk_0   <= 1'b0;
        repeat (2) @(posedge clk24);
    endtask

    task set_flip(input logic v);
        @(posedge clk24);
        vctrl_cs <= 1'b1;
        cpu_rnw  <= 1'b0;
        cpu_dout <= {7'd0, v};
        @(posedge clk24);
        vctrl_cs <= 1'b0;
        cpu_rnw  <= 1'b1;
        exp_flip <= v;
        flip_state = v;
    endtask

    task video_bus_access;
        logic [CPU_AW-1:0] a;
        for (int i = 0; i < 2**VRAM_AW + 2**PAL_AW; i++) begin
            rng = xorshift(rng);
            @(posedge clk24);
            vram_cs  <= (i < 2**VRAM_AW);
            pal_cs   <= (i >= 2**VRAM_AW);
            cpu_rnw  <= 1'b0;
            cpu_addr <= CPU_AW'(i % 2**VRAM_AW);
            cpu_dout <= rng[7:0];
            if (i < 2**VRAM_AW) vram_tb[i] = rng[7:0];
            else pal_tb[i - 2**VRAM_AW] = rng[7:0];
        end
        // Mixed writes and reads with the op in bits 1:0
        for (int i = 0; i < 400; i++) begin
            rng = xorshift(rng);
            a = rng[28:16];
            @(posedge clk24);
            cpu_addr   <= a;
            cpu_dout   <= rng[15:8];
            cpu_rnw    <= rng[1];
            vram_cs    <= !rng[0];
            pal_cs     <= rng[0];
            exp_vram_0 <= vram_tb[a[VRAM_AW-1:0]];
            exp_pal_0  <= pal_tb[a[PAL_AW-1:0]];
            vram_chk_0 <= (rng[1:0] == 2'd2);
            pal_chk_0  <= (rng[1:0] == 2'd3);
            if (rng[1:0] == 2'd0) vram_tb[a[VRAM_AW-1:0]] = rng[15:8];
            if (rng[1:0] == 2'd1) pal_tb[a[PAL_AW-1:0]] = rng[15:8];
        end
        @(posedge clk24);
        vram_cs    <= 1'b0;
        pal_cs     <= 1'b0;
        cpu_rnw    <= 1'b1;
        vram_chk_0 <= 1'b0;
        pal_chk_0  <= 1'b0;
        set_flip(1'b1);
        set_flip(1'b0);
        repeat (2) @(posedge clk24);
    endtask

    task scan_sweep;
        logic [VRAM_AW-1:0] a;
        logic [VRAM_AW-1:0] eff;
        logic [7:0] t;
        for (int pass = 0; pass < 2; pass++) begin
            set_flip(pass[0]);
            for (int i = 0; i < 150; i++) begin
                rng = xorshift(rng);
                a = rng[VRAM_AW-1:0];
                eff = flip_state ? ~a : a;
                t = vram_tb[eff];
                @(posedge clk24);
                scan_addr <= a;
                exp_rgb_0 <= {pal_tb[{t, 1'b1}][6:0], pal_tb[{t, 1'b0}]};
                rgb_chk_0 <= 1'b1;
            end
            @(posedge clk24);
            rgb_chk_0 <= 1'b0;
        end
        set_flip(1'b0);
        repeat (3) @(posedge clk24);
    endtask

    // Miss fetch and then the same address again from the cache
    task rom_fetch(input logic scr, input logic [31:0] a);
        @(posedge clk24);
        if (scr) begin
            scr_cs   <= 1'b1;
            scr_addr <= a[SCR_AW-1:0];
        end else begin
            main_cs   <= 1'b1;
            main_addr <= a[MAIN_AW-1:0];
        end
        @(posedge clk24);
        while (!(scr ? scr_ok : main_ok)) @(posedge clk24);
        if (scr) scr_cs <= 1'b0;
        else main_cs <= 1'b0;
        @(posedge clk24);
        if (scr) begin
            scr_cs  <= 1'b1;
            scr_rep <= 1'b1;
        end else begin
            main_cs  <= 1'b1;
            main_rep <= 1'b1;
        end
        repeat (2) @(posedge clk24);
        scr_cs   <= 1'b0;
        main_cs  <= 1'b0;
        scr_rep  <= 1'b0;
        main_rep <= 1'b0;
    endtask

    initial begin
        rst = 1'b1;
        main_shr_addr = '0;
        main_shr_din = '0;
        main_shr_we = 1'b0;
        sub_shr_addr = '0;
        sub_shr_din = '0;
        sub_shr_we = 1'b0;
        cpu_addr = '0;
        cpu_dout = '0;
        cpu_rnw = 1'b1;
        vram_cs = 1'b0;
        pal_cs = 1'b0;
        vctrl_cs = 1'b0;
        scan_addr = '0;
        main_addr = '0;
        main_cs = 1'b0;
        scr_addr = '0;
        scr_cs = 1'b0;
        repeat (5) @(posedge clk24);
        rst <= 1'b0;
        repeat (64) @(posedge clk24);
        finish_test("clock enables");
        shared_ram_traffic();
        finish_test("shared RAM");
        video_bus_access();
        finish_test("video CPU bus");
        scan_sweep();
        finish_test("scan pipeline");
        for (int i = 0; i < 16; i++) begin
            rng = xorshift(rng);
            rom_fetch(1'b0, rng);
            rng = xorshift(rng);
            rom_fetch(1'b1, rng);
        end
        finish_test("ROM slots");
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
design/kiwi_pkg.sv
design/kiwi_frac_cen.sv
design/kiwi_shared_ram.sv
design/kiwi_vmem.sv
design/kiwi_rom_slot.sv
design/kiwi_game.sv
testbench/tb_sdram_model.sv
testbench/tb_kiwi_game.sv
